//--- src/rv_alu_pkg.sv
package rv_alu_pkg;

    //////////////////////////////
    // Field widths
    //////////////////////////////
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 4;

    // Accepted major opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011; // Register-register
    localparam logic [6:0] opcode_op_imm = 7'b0010011; // Register-immediate

    //////////////////////////////
    // funct3 codes
    //////////////////////////////
    localparam logic [2:0] f3_add  = 3'b000; // add/sub/addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101; // srl/sra, split by funct7 bit 5
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    //////////////////////////////
    // ALU operation codes
    //////////////////////////////
    localparam logic [alu_op_w-1:0] op_add  = 4'd0;
    localparam logic [alu_op_w-1:0] op_sub  = 4'd1;
    localparam logic [alu_op_w-1:0] op_sll  = 4'd2;
    localparam logic [alu_op_w-1:0] op_slt  = 4'd3;
    localparam logic [alu_op_w-1:0] op_sltu = 4'd4;
    localparam logic [alu_op_w-1:0] op_xor  = 4'd5;
    localparam logic [alu_op_w-1:0] op_srl  = 4'd6;
    localparam logic [alu_op_w-1:0] op_sra  = 4'd7;
    localparam logic [alu_op_w-1:0] op_or   = 4'd8;
    localparam logic [alu_op_w-1:0] op_and  = 4'd9;

    // One instruction word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i_view;
    } instr_u;

endpackage

//--- src/issue_if.sv
`timescale 1ns/1ps

interface issue_if #(
    parameter int data_w = 32
);
    logic                                valid;  // One cycle per issued instruction
    logic [rv_alu_pkg::alu_op_w-1:0]     alu_op;
    logic [rv_alu_pkg::reg_addr_w-1:0]   rd;
    logic [data_w-1:0]                   opnd_a;
    logic [data_w-1:0]                   opnd_b; // rs2 data, immediate or shamt

    modport producer (
        output valid, alu_op, rd, opnd_a, opnd_b
    );

    modport consumer (
        input valid, alu_op, rd, opnd_a, opnd_b
    );

endinterface

//--- src/rf_read_if.sv
`timescale 1ns/1ps

interface rf_read_if #(
    parameter int data_w = 32
);
    logic [rv_alu_pkg::reg_addr_w-1:0] rs1_addr;
    logic [rv_alu_pkg::reg_addr_w-1:0] rs2_addr;
    logic [data_w-1:0]                 rs1_data; // Combinational return
    logic [data_w-1:0]                 rs2_data;

    modport requester (
        output rs1_addr, rs2_addr,
        input  rs1_data, rs2_data
    );

    modport responder (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );

endinterface

//--- src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder #(
    parameter int data_w = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid_i,
    input  rv_alu_pkg::instr_u instr_i,
    rf_read_if.requester       rf,
    issue_if.producer          issue
);

    logic                              supported;
    logic                              is_imm;
    logic [rv_alu_pkg::alu_op_w-1:0]   dec_op;
    logic [data_w-1:0]                 imm_ext;
    logic [data_w-1:0]                 shamt_ext;
    logic [data_w-1:0]                 opnd_b_nxt;

    //////////////////////////////
    // Operand fetch
    //////////////////////////////
    assign rf.rs1_addr = instr_i.r_view.rs1;
    assign rf.rs2_addr = instr_i.r_view.rs2;

    // Immediate from the I-type view, shamt sits in the rs2 slot
    assign imm_ext   = {{(data_w-12){instr_i.i_view.imm12[11]}}, instr_i.i_view.imm12};
    assign shamt_ext = {{(data_w-rv_alu_pkg::reg_addr_w){1'b0}}, instr_i.r_view.rs2};

    assign is_imm    = (instr_i.r_view.opcode == rv_alu_pkg::opcode_op_imm);
    assign supported = is_imm || (instr_i.r_view.opcode == rv_alu_pkg::opcode_op);

    //////////////////////////////
    // ALU op select
    //////////////////////////////
    always_comb begin
        case (instr_i.r_view.funct3)
            rv_alu_pkg::f3_add: begin
                // sub only exists in register form
                if (!is_imm && instr_i.r_view.funct7[5]) begin
                    dec_op = rv_alu_pkg::op_sub;
                end else begin
                    dec_op = rv_alu_pkg::op_add;
                end
            end
            rv_alu_pkg::f3_sll:  dec_op = rv_alu_pkg::op_sll;
            rv_alu_pkg::f3_slt:  dec_op = rv_alu_pkg::op_slt;
            rv_alu_pkg::f3_sltu: dec_op = rv_alu_pkg::op_sltu;
            rv_alu_pkg::f3_xor:  dec_op = rv_alu_pkg::op_xor;
            rv_alu_pkg::f3_sr: begin
                dec_op = instr_i.r_view.funct7[5] ? rv_alu_pkg::op_sra : rv_alu_pkg::op_srl;
            end
            rv_alu_pkg::f3_or:   dec_op = rv_alu_pkg::op_or;
            default:             dec_op = rv_alu_pkg::op_and;
        endcase
    end

    // Operand b source
    always_comb begin
        if (!is_imm) begin
            opnd_b_nxt = rf.rs2_data;
        end else if (instr_i.r_view.funct3 == rv_alu_pkg::f3_sll ||
                     instr_i.r_view.funct3 == rv_alu_pkg::f3_sr) begin
            opnd_b_nxt = shamt_ext;
        end else begin
            opnd_b_nxt = imm_ext;
        end
    end

    //////////////////////////////
    // Decode/execute register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= instr_valid_i && supported; // Drop unsupported words
        end
    end

    always_ff @(posedge clk) begin
        issue.alu_op <= dec_op;
        issue.rd     <= instr_i.r_view.rd;
        issue.opnd_a <= rf.rs1_data;
        issue.opnd_b <= opnd_b_nxt;
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int data_w = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    rf_read_if.responder                      rd_port,
    input  logic                              wb_en_i,
    input  logic [rv_alu_pkg::reg_addr_w-1:0] wb_addr_i,
    input  logic [data_w-1:0]                 wb_data_i
);

    logic [data_w-1:0] regs [1:31]; // x0 is not stored

    // One read port with write-through
    function automatic logic [data_w-1:0] read_port(
        input logic [rv_alu_pkg::reg_addr_w-1:0] addr
    );
        logic [data_w-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_en_i && wb_addr_i == addr) begin
            val = wb_data_i; // Bypass the write of this cycle
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rd_port.rs1_data = read_port(rd_port.rs1_addr);
        rd_port.rs2_data = read_port(rd_port.rs2_addr);
    end

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

endmodule

//--- src/alu_exec.sv
`timescale 1ns/1ps

module alu_exec #(
    parameter int data_w = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    issue_if.consumer                         issue,
    output logic                              wb_en_o,
    output logic [rv_alu_pkg::reg_addr_w-1:0] wb_addr_o,
    output logic [data_w-1:0]                 wb_data_o,
    output logic                              result_valid_o,
    output logic [rv_alu_pkg::reg_addr_w-1:0] result_rd_o,
    output logic [data_w-1:0]                 result_o
);

    localparam int sh_w = $clog2(data_w);

    logic [sh_w-1:0]   shamt;
    logic [data_w-1:0] alu_res;

    assign shamt = issue.opnd_b[sh_w-1:0]; // Low bits only

    //////////////////////////////
    // ALU
    //////////////////////////////
    always_comb begin
        case (issue.alu_op)
            rv_alu_pkg::op_add:  alu_res = issue.opnd_a + issue.opnd_b;
            rv_alu_pkg::op_sub:  alu_res = issue.opnd_a - issue.opnd_b;
            rv_alu_pkg::op_sll:  alu_res = issue.opnd_a << shamt;
            rv_alu_pkg::op_slt: begin
                alu_res = data_w'($signed(issue.opnd_a) < $signed(issue.opnd_b));
            end
            rv_alu_pkg::op_sltu: alu_res = data_w'(issue.opnd_a < issue.opnd_b);
            rv_alu_pkg::op_xor:  alu_res = issue.opnd_a ^ issue.opnd_b;
            rv_alu_pkg::op_srl:  alu_res = issue.opnd_a >> shamt;
            rv_alu_pkg::op_sra:  alu_res = $unsigned($signed(issue.opnd_a) >>> shamt);
            rv_alu_pkg::op_or:   alu_res = issue.opnd_a | issue.opnd_b;
            rv_alu_pkg::op_and:  alu_res = issue.opnd_a & issue.opnd_b;
            default:             alu_res = '0;
        endcase
    end

    // Writeback, taken by the register file at the next edge
    assign wb_en_o   = issue.valid;
    assign wb_addr_o = issue.rd;
    assign wb_data_o = alu_res;

    //////////////////////////////
    // Result outputs
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        result_rd_o <= issue.rd;
        result_o    <= alu_res; // Pulses even for rd x0
    end

endmodule

//--- src/rv_alu_pipe.sv
`timescale 1ns/1ps

module rv_alu_pipe #(
    parameter int data_w = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid_i,
    input  logic [31:0]       instr_i,
    output logic              result_valid_o,
    output logic [4:0]        result_rd_o,
    output logic [data_w-1:0] result_o
);

    logic                              wb_en;
    logic [rv_alu_pkg::reg_addr_w-1:0] wb_addr;
    logic [data_w-1:0]                 wb_data;

    issue_if   #(.data_w(data_w)) u_issue_if ();
    rf_read_if #(.data_w(data_w)) u_rf_read_if ();

    //////////////////////////////
    // Decode
    //////////////////////////////
    instr_decoder #(
        .data_w        (data_w)
    ) u_instr_decoder (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),      // Raw word into the union view
        .rf            (u_rf_read_if.requester),
        .issue         (u_issue_if.producer)
    );

    //////////////////////////////
    // Architectural state
    //////////////////////////////
    reg_file #(
        .data_w    (data_w)
    ) u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .rd_port   (u_rf_read_if.responder),
        .wb_en_i   (wb_en),
        .wb_addr_i (wb_addr),
        .wb_data_i (wb_data)
    );

    //////////////////////////////
    // Execute and writeback
    //////////////////////////////
    alu_exec #(
        .data_w         (data_w)
    ) u_alu_exec (
        .clk            (clk),
        .rst            (rst),
        .issue          (u_issue_if.consumer),
        .wb_en_o        (wb_en),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (wb_data),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_o       (result_o)
    );

endmodule

//--- testbench/rv_alu_pipe_chk.sv
`timescale 1ns/1ps

module rv_alu_pipe_chk #(
    parameter int data_w = 32
) (
    input logic              clk,
    input logic              rst,
    input logic              instr_valid_i,
    input logic              result_valid_i,
    input logic [4:0]        result_rd_i,
    input logic [data_w-1:0] result_i
);

    // Output strobe clears one edge after reset is seen
    assert property (@(posedge clk) rst |=> !result_valid_i)
        else $error("result_valid_o high in the cycle after reset");

    // Two register stages between the input and the result
    assert property (@(posedge clk) disable iff (rst) result_valid_i |-> $past(instr_valid_i, 2))
        else $error("result pulse without an instruction two edges earlier");

    assert property (@(posedge clk) disable iff (rst)
                     result_valid_i |-> !$isunknown({result_rd_i, result_i}))
        else $error("unknown bits on the result while result_valid_o is high");

endmodule

bind rv_alu_pipe rv_alu_pipe_chk #(
    .data_w         (data_w)
) u_rv_alu_pipe_chk (
    .clk            (clk),
    .rst            (rst),
    .instr_valid_i  (instr_valid_i),
    .result_valid_i (result_valid_o),
    .result_rd_i    (result_rd_o),
    .result_i       (result_o)
);

//--- testbench/rv_alu_pipe_tb.sv
`timescale 1ns/1ps

module rv_alu_pipe_tb;

    localparam int data_w      = 32;
    localparam int drain_limit = 20; // Cycles allowed for owed results

    logic              clk;
    logic              rst;
    logic              instr_valid_i;
    logic [31:0]       instr_i;
    logic              result_valid_o;
    logic [4:0]        result_rd_o;
    logic [data_w-1:0] result_o;

    // Program image, one entry per file line
    int          prog_test[$];
    logic [31:0] prog_word[$];
    logic [31:0] prog_exp[$];
    logic [31:0] prog_rd[$];
    logic [31:0] prog_val[$];

    // Results the pipeline still owes, oldest first
    logic [31:0] exp_rd_q[$];
    logic [31:0] exp_val_q[$];
    logic [31:0] e_rd;
    logic [31:0] e_val;

    int cur_test;
    int mon_errors;
    int pass_count;
    int fail_count;
    int load_error;

    rv_alu_pipe #(
        .data_w         (data_w)
    ) u_rv_alu_pipe (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_o       (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset";
            2:       return "immediates";
            3:       return "reg_reg_bypass";
            4:       return "x0_handling";
            5:       return "unsupported";
            default: return "unknown";
        endcase
    endfunction

    task automatic load_program();
        int          fd;
        int          n;
        int          t;
        string       line;
        logic [31:0] w;
        logic [31:0] e;
        logic [31:0] r;
        logic [31:0] v;
        fd = $fopen("testbench/program_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/program_input.txt");
            load_error = 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin // Skip comments and blank lines
                    if ($sscanf(line, "%d %h %d %d %h", t, w, e, r, v) == 5) begin
                        prog_test.push_back(t);
                        prog_word.push_back(w);
                        prog_exp.push_back(e);
                        prog_rd.push_back(r);
                        prog_val.push_back(v);
                    end else begin
                        $display("malformed line in program file: %s", line);
                        load_error = 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_instr(input int idx);
        @(posedge clk);
        #1;
        instr_valid_i = 1'b1;
        instr_i       = prog_word[idx];
        if (prog_exp[idx] != 0) begin
            exp_rd_q.push_back(prog_rd[idx]);
            exp_val_q.push_back(prog_val[idx]);
        end
    endtask

    task automatic finish_test(input int mark);
        int cycles;
        int errs;
        cycles = 0;
        errs   = 0;
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        while (exp_rd_q.size() != 0 && cycles < drain_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("test %s: %0d expected results never appeared",
                     test_name(cur_test), exp_rd_q.size());
            errs++;
            exp_rd_q.delete();
            exp_val_q.delete();
        end
        repeat (3) @(posedge clk); // Room for a stray pulse
        errs += mon_errors - mark;
        if (errs == 0) begin
            pass_count++;
            $display("test %0d %s: passed", cur_test, test_name(cur_test));
        end else begin
            fail_count++;
            $display("test %0d %s: failed with %0d errors", cur_test, test_name(cur_test), errs);
        end
    endtask

    //////////////////////////////
    // Result monitor
    //////////////////////////////
    always @(negedge clk) begin
        if (result_valid_o === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                $display("test %s: result pulse for rd %0d while no result was expected",
                         test_name(cur_test), result_rd_o);
                mon_errors++;
            end else begin
                e_rd  = exp_rd_q.pop_front();
                e_val = exp_val_q.pop_front();
                if ({27'd0, result_rd_o} !== e_rd || result_o !== e_val) begin
                    $display("mismatch test %s: expected rd %0d value %08h, actual rd %0d value %08h",
                             test_name(cur_test), e_rd, e_val, result_rd_o, result_o);
                    mon_errors++;
                end
            end
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int idx;
        int mark;
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        cur_test      = 1;
        mon_errors    = 0;
        pass_count    = 0;
        fail_count    = 0;
        load_error    = 0;
        mark          = 0; // Reset and idle pulses count against the first test
        load_program();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk); // Idle with valid low
        idx = 0;
        while (load_error == 0 && idx < prog_test.size()) begin
            cur_test = prog_test[idx];
            while (idx < prog_test.size() && prog_test[idx] == cur_test) begin
                drive_instr(idx);
                idx++;
            end
            finish_test(mark);
            mark = mon_errors;
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (load_error == 0 && fail_count == 0 && pass_count > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- testbench/program_input.txt
# Columns: test  instr(hex)  expect(1=result)  rd(dec)  value(hex)
# Lines that start with # are skipped
# Test 1: registers start at zero
1 000002b3 1 5  00000000
# Test 2: register-immediate forms
2 06400093 1 1  00000064
2 ff900113 1 2  fffffff9
2 f3808193 1 3  ffffff9c
2 ffb12213 1 4  00000001
2 00513313 1 6  00000000
2 fff0b393 1 7  00000001
2 0f00c413 1 8  00000094
2 f000e493 1 9  ffffff64
2 7f017513 1 10 000007f0
2 00409593 1 11 00000640
2 00415613 1 12 0fffffff
2 40415693 1 13 ffffffff
# Test 3: register-register chain, each reads the result just before it
3 00208733 1 14 0000005d
3 403707b3 1 15 000000c1
3 00479833 1 16 00000182
3 0101a8b3 1 17 00000001
3 0038b933 1 18 00000001
3 010949b3 1 19 00000183
3 0131da33 1 20 1ffffff3
3 4141dab3 1 21 ffffffff
3 010afb33 1 22 00000182
3 001b6bb3 1 23 000001e6
# Test 4: rd x0 still pulses, x0 keeps reading zero
4 03708013 1 0  0000009b
4 00400c33 1 24 00000001
4 00000cb3 1 25 00000000
# Test 5: load and branch words give no pulse
5 00b00d13 1 26 0000000b
5 0000ad83 0 0  00000000
5 001d0e33 1 28 0000006f
5 00208463 0 0  00000000
5 41ae0eb3 1 29 00000064

//--- rv_alu_pipe.f
src/rv_alu_pkg.sv
src/issue_if.sv
src/rf_read_if.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu_exec.sv
src/rv_alu_pipe.sv
testbench/rv_alu_pipe_chk.sv
testbench/rv_alu_pipe_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_alu_pipe_tb
FILELIST  ?= rv_alu_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation finished without failures"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
